// ==== compile.f ====
source/sap1_pkg.sv
source/program_loader.sv
source/program_ram.sv
source/sap1_sequencer.sv
source/sap1_datapath.sv
source/sap1_top.sv
testbench/sap1_assertions.sv
testbench/sap1_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SAP-1 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module sap1_tb -f compile.f -Mdir obj_dir -o sap1_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sap1_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
  exit 0
else
  echo "Simulation reported failures"
  exit 1
fi

// ==== testbench/sap1_tb.sv ====
`timescale 1ns/1ps

module sap1_tb;
  import sap1_pkg::*;

  localparam int cycle_limit = 2000;  // Six tests of about 60 cycles plus margin
  localparam int halt_latency = 15;   // Two instructions plus the HLT fetch

  logic          clk = 1'b0;
  logic          reset;
  logic          submit;
  logic          back;
  logic          use_sub;
  data_t         switch_value;
  loader_state_t loader_state;
  logic          halted;
  acc_t          acc;
  logic          overflow;
  logic          underflow;

  int errors = 0;
  int checks = 0;
  int cycle_count = 0;

  sap1_top #(.result_limit(400)) dut0 (
    .clk(clk), .reset(reset), .submit(submit), .back(back), .use_sub(use_sub),
    .switch_value(switch_value), .loader_state(loader_state), .halted(halted),
    .acc(acc), .overflow(overflow), .underflow(underflow)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic check_acc(input string name, input acc_t expected, input acc_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %0d, got %0d", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %b, got %b", name, expected, actual);
    end
  endtask

  task automatic check_state(input string name, input loader_state_t expected,
                             input loader_state_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %s, got %s", name, expected.name(), actual.name());
    end
  endtask

  task automatic check_cycles(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("FAIL %s: expected %0d, got %0d", name, expected, actual);
    end
  endtask

  // All stimulus tasks start and end on a falling edge
  task automatic apply_reset(input int cycles);
    reset = 1'b1;
    repeat (cycles) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
  endtask

  task automatic pulse_submit();
    submit = 1'b1;
    @(negedge clk);
    submit = 1'b0;
    @(negedge clk);
  endtask

  task automatic pulse_back();
    back = 1'b1;
    @(negedge clk);
    back = 1'b0;
    @(negedge clk);
  endtask

  task automatic load_program(input logic sub, input data_t a, input data_t b);
    pulse_submit();  // Leave idle
    use_sub = sub;
    pulse_submit();
    switch_value = a;
    pulse_submit();
    switch_value = b;
    pulse_submit();
  endtask

  // Cycles from the first execute cycle to halt
  task automatic wait_halted(output int exec_cycles);
    int n;
    n = 0;
    while (loader_state != st_execute) @(negedge clk);
    while (!halted) begin
      @(negedge clk);
      n++;
    end
    exec_cycles = n;
  endtask

  task automatic run_program(input string name, input logic sub, input data_t a,
                             input data_t b, input acc_t exp_acc, input logic exp_ov,
                             input logic exp_un);
    int exec_cycles;
    load_program(sub, a, b);
    wait_halted(exec_cycles);
    check_cycles({name, " halt timing"}, halt_latency, exec_cycles);
    check_acc(name, exp_acc, acc);
    check_flag({name, " overflow"}, exp_ov, overflow);
    check_flag({name, " underflow"}, exp_un, underflow);
    apply_reset(2);
  endtask

  task automatic add_random();
    int a;
    int b;
    a = $urandom_range(0, 200);  // Sum stays within the limit
    b = $urandom_range(0, 200);
    run_program("add", 1'b0, data_t'(a), data_t'(b), acc_t'(a + b), 1'b0, 1'b0);
  endtask

  task automatic sub_positive();
    int a;
    int b;
    a = $urandom_range(0, 255);
    b = $urandom_range(0, a);
    run_program("sub positive", 1'b1, data_t'(a), data_t'(b), acc_t'(a - b), 1'b0, 1'b0);
  endtask

  task automatic sub_negative();
    int a;
    int b;
    a = $urandom_range(0, 254);
    b = $urandom_range(a + 1, 255);
    run_program("sub negative", 1'b1, data_t'(a), data_t'(b), acc_t'(b - a), 1'b0, 1'b1);
  endtask

  task automatic saturating_add();
    run_program("saturating add", 1'b0, 8'd200, 8'd250, acc_t'(400), 1'b1, 1'b0);
    check_flag("reset overflow", 1'b0, overflow);  // Was high before the reset
  endtask

  task automatic back_navigation();
    int exec_cycles;
    pulse_submit();
    use_sub = 1'b0;
    pulse_submit();
    switch_value = 8'd10;
    pulse_submit();
    check_state("back nav at B", st_input_b, loader_state);
    pulse_back();
    check_state("back nav to A", st_input_a, loader_state);
    switch_value = 8'd30;
    pulse_submit();
    switch_value = 8'd5;
    pulse_submit();
    wait_halted(exec_cycles);
    check_acc("back nav add", acc_t'(35), acc);
    check_flag("back nav overflow", 1'b0, overflow);
    apply_reset(2);
    pulse_submit();
    check_state("back nav at select", st_select_prog, loader_state);
    pulse_back();
    check_state("back nav to idle", st_idle, loader_state);
  endtask

  task automatic halt_hold();
    int exec_cycles;
    load_program(1'b1, 8'd23, 8'd100);
    wait_halted(exec_cycles);
    pulse_submit();  // Ignored once halted
    pulse_back();
    pulse_back();
    check_flag("hold halted", 1'b1, halted);
    check_acc("hold acc", acc_t'(77), acc);
    check_flag("hold underflow", 1'b1, underflow);
    check_state("hold state", st_execute, loader_state);
    apply_reset(2);
    check_state("reset state", st_idle, loader_state);
    check_flag("reset halted", 1'b0, halted);
    check_acc("reset acc", acc_t'(0), acc);
    check_flag("reset underflow", 1'b0, underflow);
  endtask

  initial begin
    void'($urandom(43));
    reset        = 1'b1;
    submit       = 1'b0;
    back         = 1'b0;
    use_sub      = 1'b0;
    switch_value = '0;
    @(negedge clk);
    apply_reset(10);
    add_random();
    sub_positive();
    sub_negative();
    saturating_add();
    back_navigation();
    halt_hold();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== testbench/sap1_assertions.sv ====
`timescale 1ns/1ps

module sap1_assertions (
  input logic clk,
  input logic reset,
  input logic write_en,
  input logic run,
  input logic halted,
  input logic overflow,
  input logic underflow
);

  // Loader writes only while the core is stopped
  assert property (@(posedge clk) disable iff (reset) !(write_en && run))
    else $error("write_en and run are high in the same cycle");

  assert property (@(posedge clk) disable iff (reset) halted |-> run)
    else $error("halted is high while run is low");

  // One result cannot both saturate and go negative
  assert property (@(posedge clk) disable iff (reset) !(overflow && underflow))
    else $error("overflow and underflow are high together");

endmodule

bind sap1_top sap1_assertions asrt0 (
  .clk(clk), .reset(reset), .write_en(write_en), .run(run),
  .halted(halted), .overflow(overflow), .underflow(underflow)
);

// ==== source/sap1_top.sv ====
`timescale 1ns/1ps

module sap1_top #(
  parameter int result_limit = 9999
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    submit,
  input  logic                    back,
  input  logic                    use_sub,
  input  sap1_pkg::data_t         switch_value,
  output sap1_pkg::loader_state_t loader_state,
  output logic                    halted,
  output sap1_pkg::acc_t          acc,
  output logic                    overflow,
  output logic                    underflow
);
  import sap1_pkg::*;

  // Loader to memory
  logic    write_en;
  addr_t   write_addr;
  data_t   write_data;
  logic    run;

  // Memory and core
  addr_t   read_addr;
  data_t   read_data;
  opcode_t opcode;
  logic    pc_out_en, pc_inc, mar_load, mem_out_en, ir_load;
  logic    ir_out_en, a_load, b_load, alu_sub, acc_load;

  program_loader loader0 (
    .clk(clk), .reset(reset), .submit(submit), .back(back), .use_sub(use_sub),
    .halted(halted), .switch_value(switch_value), .write_en(write_en),
    .write_addr(write_addr), .write_data(write_data), .run(run), .state(loader_state)
  );

  program_ram ram0 (
    .clk(clk), .reset(reset), .write_en(write_en), .write_addr(write_addr),
    .read_addr(read_addr), .write_data(write_data), .read_data(read_data)
  );

  sap1_sequencer seq0 (
    .clk(clk), .reset(reset), .run(run), .opcode(opcode), .halted(halted),
    .pc_out_en(pc_out_en), .pc_inc(pc_inc), .mar_load(mar_load),
    .mem_out_en(mem_out_en), .ir_load(ir_load), .ir_out_en(ir_out_en),
    .a_load(a_load), .b_load(b_load), .alu_sub(alu_sub), .acc_load(acc_load)
  );

  sap1_datapath #(.result_limit(result_limit)) dp0 (
    .clk(clk), .reset(reset), .pc_out_en(pc_out_en), .pc_inc(pc_inc),
    .mar_load(mar_load), .mem_out_en(mem_out_en), .ir_load(ir_load),
    .ir_out_en(ir_out_en), .a_load(a_load), .b_load(b_load), .alu_sub(alu_sub),
    .acc_load(acc_load), .read_data(read_data), .read_addr(read_addr),
    .opcode(opcode), .acc(acc), .overflow(overflow), .underflow(underflow)
  );

endmodule

// ==== source/sap1_datapath.sv ====
`timescale 1ns/1ps

module sap1_datapath #(
  parameter int result_limit = 9999
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              pc_out_en,
  input  logic              pc_inc,
  input  logic              mar_load,
  input  logic              mem_out_en,
  input  logic              ir_load,
  input  logic              ir_out_en,
  input  logic              a_load,
  input  logic              b_load,
  input  logic              alu_sub,
  input  logic              acc_load,
  input  sap1_pkg::data_t   read_data,
  output sap1_pkg::addr_t   read_addr,
  output sap1_pkg::opcode_t opcode,
  output sap1_pkg::acc_t    acc,
  output logic              overflow,
  output logic              underflow
);
  import sap1_pkg::*;

  addr_t pc;
  addr_t mar;
  data_t ir;
  data_t a_reg;
  data_t b_reg;
  data_t bus;
  acc_t  sum;
  acc_t  diff_mag;
  logic  borrow;

  // Memory wins over PC, PC over IR operand
  always_comb begin
    if (mem_out_en)     bus = read_data;
    else if (pc_out_en) bus = {4'd0, pc};
    else if (ir_out_en) bus = {4'd0, ir[3:0]};
    else                bus = '0;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc    <= '0;
      mar   <= '0;
      ir    <= '0;
      a_reg <= '0;
      b_reg <= '0;
    end else begin
      if (pc_inc && pc != 4'd15) pc <= pc + 1'b1;  // Sticks at the top address
      if (mar_load) mar <= bus[3:0];
      if (ir_load) ir <= bus;
      if (a_load) a_reg <= bus;
      if (b_load) b_reg <= bus;
    end
  end

  assign read_addr = mar;
  assign opcode    = opcode_t'(ir[7:4]);

  // ALU
  assign sum      = acc_t'(a_reg) + acc_t'(b_reg);
  assign borrow   = (a_reg < b_reg);
  assign diff_mag = borrow ? acc_t'(b_reg - a_reg) : acc_t'(a_reg - b_reg);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc       <= '0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else if (acc_load) begin
      if (alu_sub) begin
        acc       <= diff_mag;  // Sign carried by underflow
        overflow  <= 1'b0;
        underflow <= borrow;
      end else if (sum > result_limit) begin
        acc       <= acc_t'(result_limit);
        overflow  <= 1'b1;
        underflow <= 1'b0;
      end else begin
        acc       <= sum;
        overflow  <= 1'b0;
        underflow <= 1'b0;
      end
    end
  end

endmodule

// ==== source/sap1_sequencer.sv ====
`timescale 1ns/1ps

module sap1_sequencer (
  input  logic              clk,
  input  logic              reset,
  input  logic              run,
  input  sap1_pkg::opcode_t opcode,
  output logic              halted,
  output logic              pc_out_en,
  output logic              pc_inc,
  output logic              mar_load,
  output logic              mem_out_en,
  output logic              ir_load,
  output logic              ir_out_en,
  output logic              a_load,
  output logic              b_load,
  output logic              alu_sub,
  output logic              acc_load
);
  import sap1_pkg::*;

  logic [step_width-1:0] step;

  // Ring of six steps that holds at step 3 on HLT
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      step <= '0;
    end else if (!run) begin
      step <= '0;
    end else if (!halted) begin
      step <= (step == step_count - 1) ? '0 : step + 1'b1;
    end
  end

  always_comb begin
    halted     = 1'b0;
    pc_out_en  = 1'b0;
    pc_inc     = 1'b0;
    mar_load   = 1'b0;
    mem_out_en = 1'b0;
    ir_load    = 1'b0;
    ir_out_en  = 1'b0;
    a_load     = 1'b0;
    b_load     = 1'b0;
    alu_sub    = 1'b0;
    acc_load   = 1'b0;
    if (run) begin
      case (step)
        0: begin  // Fetch address
          pc_out_en = 1'b1;
          mar_load  = 1'b1;
        end
        1: pc_inc = 1'b1;
        2: begin
          mem_out_en = 1'b1;
          ir_load    = 1'b1;
        end
        3: begin
          if (opcode == op_hlt) begin
            halted = 1'b1;
          end else begin
            ir_out_en = 1'b1;  // Operand address into MAR
            mar_load  = 1'b1;
          end
        end
        4: begin
          mem_out_en = 1'b1;
          a_load     = (opcode == op_lda);
          b_load     = (opcode == op_add) || (opcode == op_sub);
        end
        5: begin
          alu_sub  = (opcode == op_sub);
          acc_load = (opcode == op_add) || (opcode == op_sub);
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== source/program_ram.sv ====
`timescale 1ns/1ps

module program_ram (
  input  logic            clk,
  input  logic            reset,
  input  logic            write_en,
  input  sap1_pkg::addr_t write_addr,
  input  sap1_pkg::addr_t read_addr,
  input  sap1_pkg::data_t write_data,
  output sap1_pkg::data_t read_data
);
  import sap1_pkg::*;

  data_t mem [ram_depth];

  // Loader side, one word per enabled edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < ram_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (write_en) begin
      mem[write_addr] <= write_data;
    end
  end

  assign read_data = mem[read_addr];  // Core side, no latency

endmodule

// ==== source/program_loader.sv ====
`timescale 1ns/1ps

module program_loader (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      submit,
  input  logic                      back,
  input  logic                      use_sub,
  input  logic                      halted,
  input  sap1_pkg::data_t           switch_value,
  output logic                      write_en,
  output sap1_pkg::addr_t           write_addr,
  output sap1_pkg::data_t           write_data,
  output logic                      run,
  output sap1_pkg::loader_state_t   state
);
  import sap1_pkg::*;

  logic     sub_sel;   // Latched program choice
  data_t    a_value;
  data_t    b_value;
  logic [2:0] word_idx;  // Position in the program image
  opcode_t  arith_op;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= st_idle;
      sub_sel  <= 1'b0;
      a_value  <= '0;
      b_value  <= '0;
      word_idx <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (submit) state <= st_select_prog;
        end
        st_select_prog: begin
          if (submit) begin
            sub_sel <= use_sub;
            state   <= st_input_a;
          end else if (back) begin
            state <= st_idle;
          end
        end
        st_input_a: begin
          if (submit) begin
            a_value <= switch_value;
            state   <= st_input_b;
          end else if (back) begin
            state <= st_select_prog;
          end
        end
        st_input_b: begin
          if (submit) begin
            b_value  <= switch_value;
            word_idx <= '0;
            state    <= st_write_ram;
          end else if (back) begin
            state <= st_input_a;
          end
        end
        st_write_ram: state <= st_write_wait;  // Word lands on this edge
        st_write_wait: begin
          if (word_idx == image_words - 1) begin
            state <= st_execute;
          end else begin
            word_idx <= word_idx + 1'b1;
            state    <= st_write_ram;
          end
        end
        st_execute: begin
          // Halted core holds until reset
          if (back && !halted) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign arith_op = sub_sel ? op_sub : op_add;
  assign write_en = (state == st_write_ram);
  assign run      = (state == st_execute);

  // Image word for the current index
  always_comb begin
    write_addr = addr_t'(word_idx);
    write_data = '0;
    if (word_idx < prog_length) begin
      case (word_idx)
        3'd0:    write_data = {op_lda, addr_operand_a};
        3'd1:    write_data = {arith_op, addr_operand_b};
        default: write_data = {op_hlt, 4'd0};
      endcase
    end else if (word_idx == prog_length) begin
      write_addr = addr_operand_b;
      write_data = b_value;
    end else begin
      write_addr = addr_operand_a;
      write_data = a_value;
    end
  end

endmodule

// ==== source/sap1_pkg.sv ====
package sap1_pkg;

  // Word sizes
  localparam int data_width = 8;
  localparam int addr_width = 4;
  localparam int acc_width  = 16;

  typedef logic [data_width-1:0] data_t;  // Bus and memory word
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [acc_width-1:0]  acc_t;   // Wide enough for the display limit

  // Upper nibble of an instruction word
  typedef enum logic [3:0] {
    op_lda = 4'd0,
    op_add = 4'd1,
    op_sub = 4'd2,
    op_hlt = 4'd15
  } opcode_t;

  // Operator-facing loader FSM
  typedef enum logic [2:0] {
    st_idle,
    st_select_prog,
    st_input_a,
    st_input_b,
    st_write_ram,
    st_write_wait,
    st_execute
  } loader_state_t;

  localparam int ram_depth = 16;

  // Memory map of the loaded program
  localparam addr_t addr_operand_a = 4'd15;
  localparam addr_t addr_operand_b = 4'd14;
  localparam int prog_length = 3;   // LDA, ADD/SUB, HLT at 0..2
  localparam int image_words = 5;   // Instructions plus both operands

  // Instruction cycle
  localparam int step_count = 6;
  localparam int step_width = $clog2(step_count);

endpackage
